// ==== design/calc_pkg.sv ====
package calc_pkg;

	localparam int VALUE_W    = 20;        // holds 999999
	localparam int NUM_DIGITS = 6;
	localparam int VALUE_MAX  = 999999;

	// codes 0-9 are the digit keys
	typedef logic [3:0] key_code_t;

	localparam key_code_t KEY_ADD = 4'd10;
	localparam key_code_t KEY_SUB = 4'd11;
	localparam key_code_t KEY_MUL = 4'd12;
	localparam key_code_t KEY_DIV = 4'd13;
	localparam key_code_t KEY_CLR = 4'd14;
	localparam key_code_t KEY_EQ  = 4'd15;

	typedef struct packed {
		key_code_t code;                 // row * 4 + column
	} key_event_t;

	typedef enum logic [2:0] {
		OP_NONE,
		OP_ADD,
		OP_SUB,
		OP_MUL,
		OP_DIV
	} calc_op_t;

	typedef struct packed {
		logic [VALUE_W-1:0] value;
		logic               err;         // show E instead of value
	} disp_req_t;

endpackage

// ==== design/credit_fifo.sv ====
`timescale 1ns/10ps
module credit_fifo #(
	parameter type payload_t  = logic [7:0],
	parameter int  FIFO_DEPTH = 4
) (
	input  logic     sys_clk,
	input  logic     reset,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     credit,
	output logic     out_valid,
	output payload_t out_data,
	input  logic     pop
);

	localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

	payload_t         mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_pop;

	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;  // depth need not be 2^n
	endfunction

	assign out_valid = (count != '0);
	assign out_data  = mem[rd_ptr];
	assign do_pop    = pop && out_valid;
	assign credit    = do_pop;      // one credit back per removed entry

	always_ff @(posedge sys_clk) begin
		if (in_valid) begin
			mem[wr_ptr] <= in_data;
		end
	end

	// sender never writes without a credit, so no full check here
	always_ff @(posedge sys_clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (in_valid) begin
				wr_ptr <= ptr_inc(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= ptr_inc(rd_ptr);
			end
			count <= count + CNT_W'(in_valid) - CNT_W'(do_pop);
		end
	end

endmodule

// ==== design/keypad_scan.sv ====
`timescale 1ns/10ps
module keypad_scan #(
	parameter int SCAN_CYCLES    = 50000,
	parameter int DEBOUNCE_SCANS = 10,
	parameter int FIFO_DEPTH     = 4
) (
	input  logic                 sys_clk,
	input  logic                 reset,
	input  logic [3:0]           row,         // active low
	output logic [3:0]           col,
	output logic                 key_valid,
	output calc_pkg::key_event_t key_data,
	input  logic                 key_credit
);
	import calc_pkg::*;

	localparam int SCAN_W = $clog2(SCAN_CYCLES + 1);
	localparam int DEB_W  = $clog2(DEBOUNCE_SCANS + 1);
	localparam int CRED_W = $clog2(FIFO_DEPTH + 1);

	typedef enum logic [1:0] {HIT_NONE, HIT_ONE, HIT_MANY} hit_t;

	logic [3:0]        row_meta;
	logic [3:0]        row_sync;
	logic [3:0]        row_low;
	logic [1:0]        row_idx;
	logic [SCAN_W-1:0] scan_cnt;
	logic [1:0]        col_idx;
	logic              col_end;
	logic              scan_end;
	hit_t              col_hit;
	hit_t              scan_hit;     // result so far in this scan
	hit_t              scan_next;
	key_code_t         scan_code;
	key_code_t         next_code;
	key_code_t         cur_code;
	hit_t              prev_hit;
	key_code_t         prev_code;
	logic              same;
	logic [DEB_W-1:0]  stable_cnt;
	logic [DEB_W-1:0]  stable_next;
	logic              armed;        // cleared once a press is taken
	logic              pend;
	key_code_t         pend_code;
	logic [CRED_W-1:0] credit_cnt;

	assign col       = ~(4'b0001 << col_idx);
	assign row_low   = ~row_sync;
	// row is sampled on the last cycle of a column, after the two sync stages
	assign col_end   = (scan_cnt == SCAN_W'(SCAN_CYCLES - 1));
	assign scan_end  = col_end && (col_idx == 2'd3);
	assign key_valid = pend && (credit_cnt != '0);
	assign key_data  = key_event_t'{code: pend_code};

	always_comb begin
		row_idx = 2'd0;
		for (int r = 0; r < 4; r++) begin
			if (row_low[r]) begin
				row_idx = 2'(r);
			end
		end
		if (row_low == 4'd0) begin
			col_hit = HIT_NONE;
		end else if ((row_low & (row_low - 4'd1)) == 4'd0) begin
			col_hit = HIT_ONE;
		end else begin
			col_hit = HIT_MANY;
		end
		if (col_hit == HIT_NONE) begin
			scan_next = scan_hit;
			next_code = scan_code;
		end else if (col_hit == HIT_ONE && scan_hit == HIT_NONE) begin
			scan_next = HIT_ONE;
			next_code = {row_idx, col_idx};
		end else begin
			scan_next = HIT_MANY;  // ghosting or chord, never a key
			next_code = scan_code;
		end
		cur_code = (scan_next == HIT_ONE) ? next_code : '0;
		same     = (scan_next == prev_hit) && (cur_code == prev_code);
		if (!same) begin
			stable_next = DEB_W'(1);
		end else if (stable_cnt == DEB_W'(DEBOUNCE_SCANS)) begin
			stable_next = stable_cnt;
		end else begin
			stable_next = stable_cnt + 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		row_meta <= row;
		row_sync <= row_meta;
		if (reset) begin
			scan_cnt   <= '0;
			col_idx    <= '0;
			scan_hit   <= HIT_NONE;
			scan_code  <= '0;
			prev_hit   <= HIT_NONE;
			prev_code  <= '0;
			stable_cnt <= '0;
			armed      <= 1'b1;
			pend       <= 1'b0;
			credit_cnt <= CRED_W'(FIFO_DEPTH);
		end else begin
			scan_cnt <= col_end ? '0 : scan_cnt + 1'b1;
			if (col_end) begin
				col_idx   <= col_idx + 1'b1;
				scan_hit  <= scan_end ? HIT_NONE : scan_next;
				scan_code <= scan_end ? '0 : next_code;
			end
			if (scan_end) begin
				prev_hit   <= scan_next;
				prev_code  <= cur_code;
				stable_cnt <= stable_next;
				if (stable_next == DEB_W'(DEBOUNCE_SCANS)) begin
					if (scan_next == HIT_NONE) begin
						armed <= 1'b1;           // released long enough
					end else if (scan_next == HIT_ONE && armed) begin
						armed <= 1'b0;
						if (!pend) begin       // dropped while still blocked
							pend      <= 1'b1;
							pend_code <= cur_code;
						end
					end
				end
			end
			if (key_valid) begin
				pend <= 1'b0;
			end
			credit_cnt <= credit_cnt - CRED_W'(key_valid) + CRED_W'(key_credit);
		end
	end

endmodule

// ==== design/calc_core.sv ====
`timescale 1ns/10ps
module calc_core #(
	parameter int FIFO_DEPTH  = 4,
	parameter int BEEP_CYCLES = 5000000
) (
	input  logic                 sys_clk,
	input  logic                 reset,
	input  logic                 key_valid,
	input  calc_pkg::key_event_t key_data,
	output logic                 key_pop,
	output logic                 disp_valid,
	output calc_pkg::disp_req_t  disp_data,
	input  logic                 disp_credit,
	output logic                 beep,
	output logic [1:0]           led
);
	import calc_pkg::*;

	localparam int CRED_W = $clog2(FIFO_DEPTH + 1);
	localparam int BEEP_W = $clog2(BEEP_CYCLES + 1);
	localparam int DCNT_W = $clog2(VALUE_W + 1);

	typedef enum logic [1:0] {ST_IDLE, ST_DIV, ST_SEND} state_t;

	state_t               state;
	logic [VALUE_W-1:0]   entry;        // divisor during ST_DIV
	logic [VALUE_W-1:0]   acc;          // dividend, then quotient
	logic [VALUE_W-1:0]   rem;
	logic [DCNT_W-1:0]    div_cnt;
	calc_op_t             op;
	logic                 digits;
	logic                 err;
	logic                 show_acc;
	logic [CRED_W-1:0]    credit_cnt;
	logic [BEEP_W-1:0]    beep_cnt;
	key_code_t            code;
	logic [VALUE_W-1:0]   entry_next;
	logic [VALUE_W:0]     sum;
	logic [2*VALUE_W-1:0] prod;
	logic [VALUE_W:0]     shifted;

	assign key_pop    = (state == ST_IDLE) && key_valid;
	assign disp_valid = (state == ST_SEND) && (credit_cnt != '0);
	assign disp_data  = disp_req_t'{value: show_acc ? acc : entry, err: err};
	assign beep       = (beep_cnt != '0);
	assign led        = {err, op != OP_NONE};

	always_comb begin
		code       = key_data.code;
		entry_next = VALUE_W'(entry * 10 + code);
		sum        = {1'b0, acc} + {1'b0, entry};
		prod       = acc * entry;
		shifted    = {rem, acc[VALUE_W-1]};
	end

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			state    <= ST_IDLE;
			entry    <= '0;
			acc      <= '0;
			op       <= OP_NONE;
			digits   <= 1'b0;
			err      <= 1'b0;
			show_acc <= 1'b0;
			div_cnt  <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (key_pop) begin
						state <= ST_SEND;
						if (code == KEY_CLR) begin
							entry    <= '0;
							acc      <= '0;
							op       <= OP_NONE;
							digits   <= 1'b0;
							err      <= 1'b0;
							show_acc <= 1'b0;
						end else if (err) begin
							show_acc <= show_acc;  // locked until clear
						end else if (code <= 4'd9) begin
							show_acc <= 1'b0;
							if (entry <= VALUE_W'(99999)) begin  // six digits max
								entry  <= entry_next;
								digits <= 1'b1;
							end
						end else if (code == KEY_EQ) begin
							show_acc <= 1'b1;
							digits   <= 1'b0;
							op       <= OP_NONE;
							if (op != OP_DIV) begin
								entry <= '0;
							end
							case (op)
								OP_ADD: begin
									if (sum > VALUE_MAX) err <= 1'b1;
									else acc <= sum[VALUE_W-1:0];
								end
								OP_SUB: begin
									if (entry > acc) err <= 1'b1;   // would go negative
									else acc <= acc - entry;
								end
								OP_MUL: begin
									if (prod > VALUE_MAX) err <= 1'b1;
									else acc <= prod[VALUE_W-1:0];
								end
								OP_DIV: begin
									if (entry == '0) begin
										err <= 1'b1;
									end else begin
										rem     <= '0;
										div_cnt <= DCNT_W'(VALUE_W);
										state   <= ST_DIV;
									end
								end
								default: acc <= entry;
							endcase
						end else begin
							show_acc <= 1'b0;
							if (digits) begin
								acc <= entry;
							end
							entry  <= '0;
							digits <= 1'b0;
							case (code)
								KEY_ADD: op <= OP_ADD;
								KEY_SUB: op <= OP_SUB;
								KEY_MUL: op <= OP_MUL;
								default: op <= OP_DIV;
							endcase
						end
					end
				end
				ST_DIV: begin
					// restoring step, one quotient bit per cycle
					if (shifted >= {1'b0, entry}) begin
						rem <= VALUE_W'(shifted - {1'b0, entry});
						acc <= {acc[VALUE_W-2:0], 1'b1};
					end else begin
						rem <= shifted[VALUE_W-1:0];
						acc <= {acc[VALUE_W-2:0], 1'b0};
					end
					div_cnt <= div_cnt - 1'b1;
					if (div_cnt == DCNT_W'(1)) begin
						entry <= '0;
						state <= ST_SEND;
					end
				end
				default: begin
					if (credit_cnt != '0) begin
						state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			credit_cnt <= CRED_W'(FIFO_DEPTH);
			beep_cnt   <= '0;
		end else begin
			credit_cnt <= credit_cnt - CRED_W'(disp_valid) + CRED_W'(disp_credit);
			if (key_pop) begin
				beep_cnt <= BEEP_W'(BEEP_CYCLES);  // ignored keys beep too
			end else if (beep_cnt != '0) begin
				beep_cnt <= beep_cnt - 1'b1;
			end
		end
	end

endmodule

// ==== design/seg_display.sv ====
`timescale 1ns/10ps
module seg_display #(
	parameter int DIGIT_CYCLES = 50000
) (
	input  logic                sys_clk,
	input  logic                reset,
	input  logic                req_valid,
	input  calc_pkg::disp_req_t req_data,
	output logic                req_pop,
	output logic [2:0]          sel,
	output logic [7:0]          seg          // {dp, g..a}, active low
);
	import calc_pkg::*;

	localparam int BCD_W = 4 * NUM_DIGITS;
	localparam int DIG_W = $clog2(DIGIT_CYCLES + 1);
	localparam int CNT_W = $clog2(VALUE_W + 1);

	localparam logic [7:0] SEG_E     = 8'h86;
	localparam logic [7:0] SEG_BLANK = 8'hff;

	logic               busy;
	logic [CNT_W-1:0]   conv_cnt;
	logic [VALUE_W-1:0] bin;
	logic [BCD_W-1:0]   bcd;
	logic [BCD_W-1:0]   bcd_adj;
	logic [BCD_W-1:0]   bcd_next;
	logic               conv_err;
	logic [BCD_W-1:0]   shown;
	logic               shown_err;
	logic [DIG_W-1:0]   dig_cnt;
	logic [3:0]         cur_digit;
	logic               blank;

	assign req_pop = !busy && req_valid;

	// shift-and-add-three, one input bit per cycle
	always_comb begin
		bcd_adj = bcd;
		for (int i = 0; i < NUM_DIGITS; i++) begin
			if (bcd[4*i +: 4] >= 4'd5) begin
				bcd_adj[4*i +: 4] = bcd[4*i +: 4] + 4'd3;
			end
		end
		bcd_next = {bcd_adj[BCD_W-2:0], bin[VALUE_W-1]};
	end

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			busy      <= 1'b0;
			conv_cnt  <= '0;
			shown     <= '0;
			shown_err <= 1'b0;
		end else if (req_pop) begin
			busy     <= 1'b1;
			conv_cnt <= CNT_W'(VALUE_W);
			bin      <= req_data.value;
			conv_err <= req_data.err;
			bcd      <= '0;
		end else if (busy) begin
			bcd      <= bcd_next;
			bin      <= bin << 1;
			conv_cnt <= conv_cnt - 1'b1;
			if (conv_cnt == CNT_W'(1)) begin
				busy      <= 1'b0;
				shown     <= bcd_next;   // old value stays lit until here
				shown_err <= conv_err;
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (reset) begin
			dig_cnt <= '0;
			sel     <= 3'd0;
		end else if (dig_cnt == DIG_W'(DIGIT_CYCLES - 1)) begin
			dig_cnt <= '0;
			sel     <= (sel == 3'(NUM_DIGITS - 1)) ? 3'd0 : sel + 3'd1;
		end else begin
			dig_cnt <= dig_cnt + 1'b1;
		end
	end

	always_comb begin
		cur_digit = shown[4*sel +: 4];
		blank     = (sel != 3'd0) && ((shown >> (4 * sel)) == '0);  // leading zero
		if (shown_err) begin
			seg = (sel == 3'd0) ? SEG_E : SEG_BLANK;
		end else if (blank) begin
			seg = SEG_BLANK;
		end else begin
			case (cur_digit)
				4'd0:    seg = 8'hc0;
				4'd1:    seg = 8'hf9;
				4'd2:    seg = 8'ha4;
				4'd3:    seg = 8'hb0;
				4'd4:    seg = 8'h99;
				4'd5:    seg = 8'h92;
				4'd6:    seg = 8'h82;
				4'd7:    seg = 8'hf8;
				4'd8:    seg = 8'h80;
				4'd9:    seg = 8'h90;
				default: seg = SEG_BLANK;
			endcase
		end
	end

endmodule

// ==== design/calc_top.sv ====
`timescale 1ns/10ps
module calc_top #(
	parameter int SCAN_CYCLES    = 50000,     // 1 ms per column at 50 MHz
	parameter int DEBOUNCE_SCANS = 5,
	parameter int FIFO_DEPTH     = 4,
	parameter int DIGIT_CYCLES   = 50000,
	parameter int BEEP_CYCLES    = 5000000
) (
	input  logic       sys_clk,
	input  logic       reset,
	input  logic [3:0] row,
	output logic [3:0] col,
	output logic [2:0] sel,
	output logic [7:0] seg,
	output logic       beep,
	output logic [1:0] led
);
	import calc_pkg::*;

	logic       key_valid;
	key_event_t key_data;
	logic       key_credit;
	logic       key_q_valid;
	key_event_t key_q_data;
	logic       key_pop;
	logic       disp_valid;
	disp_req_t  disp_data;
	logic       disp_credit;
	logic       disp_q_valid;
	disp_req_t  disp_q_data;
	logic       disp_pop;

	keypad_scan #(
		.SCAN_CYCLES    (SCAN_CYCLES),
		.DEBOUNCE_SCANS (DEBOUNCE_SCANS),
		.FIFO_DEPTH     (FIFO_DEPTH)
	) scan_i (
		.sys_clk    (sys_clk),
		.reset      (reset),
		.row        (row),
		.col        (col),
		.key_valid  (key_valid),
		.key_data   (key_data),
		.key_credit (key_credit)
	);

	credit_fifo #(
		.payload_t  (key_event_t),
		.FIFO_DEPTH (FIFO_DEPTH)
	) key_fifo (
		.sys_clk   (sys_clk),
		.reset     (reset),
		.in_valid  (key_valid),
		.in_data   (key_data),
		.credit    (key_credit),
		.out_valid (key_q_valid),
		.out_data  (key_q_data),
		.pop       (key_pop)
	);

	calc_core #(
		.FIFO_DEPTH  (FIFO_DEPTH),
		.BEEP_CYCLES (BEEP_CYCLES)
	) core_i (
		.sys_clk     (sys_clk),
		.reset       (reset),
		.key_valid   (key_q_valid),
		.key_data    (key_q_data),
		.key_pop     (key_pop),
		.disp_valid  (disp_valid),
		.disp_data   (disp_data),
		.disp_credit (disp_credit),
		.beep        (beep),
		.led         (led)
	);

	credit_fifo #(
		.payload_t  (disp_req_t),
		.FIFO_DEPTH (FIFO_DEPTH)
	) disp_fifo (
		.sys_clk   (sys_clk),
		.reset     (reset),
		.in_valid  (disp_valid),
		.in_data   (disp_data),
		.credit    (disp_credit),
		.out_valid (disp_q_valid),
		.out_data  (disp_q_data),
		.pop       (disp_pop)
	);

	seg_display #(
		.DIGIT_CYCLES (DIGIT_CYCLES)
	) display_i (
		.sys_clk   (sys_clk),
		.reset     (reset),
		.req_valid (disp_q_valid),
		.req_data  (disp_q_data),
		.req_pop   (disp_pop),
		.sel       (sel),
		.seg       (seg)
	);

endmodule

// ==== verif/keypad_model.sv ====
`timescale 1ns/10ps
module keypad_model (
	input  logic [3:0] col,         // one column driven low at a time
	input  logic       pressed,
	input  logic [3:0] key,         // row * 4 + column
	output logic [3:0] row          // pulled high, low on a closed switch
);

	logic [1:0] key_row;
	logic [1:0] key_col;

	assign key_row = key[3:2];
	assign key_col = key[1:0];

	// a closed switch connects its column line to its row line
	always_comb begin
		row = 4'hf;
		if (pressed && !col[key_col]) begin
			row[key_row] = 1'b0;
		end
	end

endmodule

// ==== verif/calc_tb.sv ====
`timescale 1ns/10ps
module calc_tb;
	import calc_pkg::*;

	localparam int SCAN_CYCLES    = 4;
	localparam int DEBOUNCE_SCANS = 2;
	localparam int FIFO_DEPTH     = 2;
	localparam int DIGIT_CYCLES   = 4;
	localparam int BEEP_CYCLES    = 8;

	localparam int SCAN_TIME      = 4 * SCAN_CYCLES;
	localparam int HOLD_CYCLES    = 2 * DEBOUNCE_SCANS * SCAN_TIME;   // press, then release
	localparam int SETTLE_CYCLES  = SCAN_TIME + (VALUE_W + 1) + VALUE_W + 8;
	localparam int REFRESH_CYCLES = NUM_DIGITS * DIGIT_CYCLES;
	localparam int KEY_CYCLES     = 2 * HOLD_CYCLES + SETTLE_CYCLES + REFRESH_CYCLES;
	localparam int MAX_KEYS       = 160;
	localparam int TIMEOUT_CYCLES = MAX_KEYS * KEY_CYCLES + 2000;

	typedef struct packed {
		logic [31:0] entry;
		logic [31:0] acc;
		calc_op_t    op;
		logic        digits;
		logic        err;
		logic        show_acc;
	} ref_state_t;

	logic       sys_clk = 1'b0;
	logic       reset;
	logic [3:0] row;
	logic [3:0] col;
	logic [2:0] sel;
	logic [7:0] seg;
	logic       beep;
	logic [1:0] led;
	logic       pressed;
	logic [3:0] key;
	logic       beep_q = 1'b0;
	int         beep_rises = 0;
	int         cycle_cnt = 0;
	ref_state_t model_st;

	always #5 sys_clk = ~sys_clk;

	calc_top #(
		.SCAN_CYCLES    (SCAN_CYCLES),
		.DEBOUNCE_SCANS (DEBOUNCE_SCANS),
		.FIFO_DEPTH     (FIFO_DEPTH),
		.DIGIT_CYCLES   (DIGIT_CYCLES),
		.BEEP_CYCLES    (BEEP_CYCLES)
	) dut_i (
		.sys_clk (sys_clk),
		.reset   (reset),
		.row     (row),
		.col     (col),
		.sel     (sel),
		.seg     (seg),
		.beep    (beep),
		.led     (led)
	);

	keypad_model keypad_i (
		.col     (col),
		.pressed (pressed),
		.key     (key),
		.row     (row)
	);

	always @(posedge sys_clk) begin
		beep_q <= beep;
		if (beep && !beep_q) begin
			beep_rises <= beep_rises + 1;   // one per accepted key
		end
	end

	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

	// expected calculator state after one key
	function automatic ref_state_t calc_ref(input ref_state_t s, input logic [3:0] k);
		ref_state_t  n;
		logic [63:0] res;
		n   = s;
		res = '0;
		if (k == KEY_CLR) begin
			n = '0;
		end else if (s.err) begin
			n = s;                          // only clear leaves the error
		end else if (k <= 4'd9) begin
			n.show_acc = 1'b0;
			if (s.entry < 32'd100000) begin
				n.entry  = s.entry * 10 + 32'(k);
				n.digits = 1'b1;
			end
		end else if (k == KEY_EQ) begin
			n.show_acc = 1'b1;
			n.digits   = 1'b0;
			n.op       = OP_NONE;
			n.entry    = '0;
			case (s.op)
				OP_ADD:  res = 64'(s.acc) + 64'(s.entry);
				OP_SUB:  res = (s.entry > s.acc) ? '1 : 64'(s.acc - s.entry);
				OP_MUL:  res = 64'(s.acc) * 64'(s.entry);
				OP_DIV:  res = (s.entry == 0) ? '1 : 64'(s.acc / s.entry);
				default: res = 64'(s.entry);
			endcase
			if (res > 64'(VALUE_MAX)) begin
				n.err = 1'b1;                 // negative, too large or divide by zero
			end else begin
				n.acc = res[31:0];
			end
		end else begin
			n.show_acc = 1'b0;
			if (s.digits) begin
				n.acc = s.entry;
			end
			n.entry  = '0;
			n.digits = 1'b0;
			case (k)
				KEY_ADD: n.op = OP_ADD;
				KEY_SUB: n.op = OP_SUB;
				KEY_MUL: n.op = OP_MUL;
				default: n.op = OP_DIV;
			endcase
		end
		return n;
	endfunction

	function automatic int seg_to_digit(input logic [7:0] s);
		case (s)
			8'hc0:   return 0;
			8'hf9:   return 1;
			8'ha4:   return 2;
			8'hb0:   return 3;
			8'h99:   return 4;
			8'h92:   return 5;
			8'h82:   return 6;
			8'hf8:   return 7;
			8'h80:   return 8;
			8'h90:   return 9;
			8'h86:   return 10;              // E
			8'hff:   return 11;              // blank
			default: return -1;
		endcase
	endfunction

	function automatic logic [3:0] char_to_key(input byte c);
		case (c)
			"+":     return KEY_ADD;
			"-":     return KEY_SUB;
			"*":     return KEY_MUL;
			"/":     return KEY_DIV;
			"C":     return KEY_CLR;
			"=":     return KEY_EQ;
			default: return 4'(c - "0");
		endcase
	endfunction

	task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, actual,
				expected);
			$display("SOME TESTS FAILED");
			$fatal(1, "mismatch");
		end
	endtask

	// one full refresh, decoded back to a number or E
	task automatic read_display(output logic [31:0] value, output logic is_err);
		logic [7:0] shown [NUM_DIGITS];
		int         d;
		int         scale;
		logic       blanked;
		logic       bad;
		for (int i = 0; i < REFRESH_CYCLES; i++) begin
			@(negedge sys_clk);
			shown[sel] = seg;
		end
		value   = '0;
		is_err  = 1'b0;
		bad     = 1'b0;
		blanked = 1'b0;
		scale   = 1;
		if (seg_to_digit(shown[0]) == 10) begin
			is_err = 1'b1;
			for (int i = 1; i < NUM_DIGITS; i++) begin
				if (seg_to_digit(shown[i]) != 11) bad = 1'b1;
			end
		end else begin
			for (int i = 0; i < NUM_DIGITS; i++) begin
				d = seg_to_digit(shown[i]);
				if (d == 11 && i != 0) begin
					blanked = 1'b1;           // leading zeros from here up
				end else if (d >= 0 && d <= 9 && !blanked) begin
					value = value + 32'(d * scale);
				end else begin
					bad = 1'b1;
				end
				scale = scale * 10;
			end
		end
		if (bad) begin
			$display("display shows a pattern that is not a number or E at %0t", $time);
			$display("SOME TESTS FAILED");
			$fatal(1, "bad display");
		end
	endtask

	task automatic check_display();
		logic [31:0] value;
		logic        is_err;
		read_display(value, is_err);
		check_eq(32'(is_err), 32'(model_st.err), "error shown");
		if (!model_st.err) begin
			check_eq(value, model_st.show_acc ? model_st.acc : model_st.entry, "shown value");
		end
		check_eq(32'(led), 32'({model_st.err, model_st.op != OP_NONE}), "led");
	endtask

	task automatic check_value(input logic [31:0] expected, input logic expect_err);
		logic [31:0] value;
		logic        is_err;
		read_display(value, is_err);
		check_eq(32'(is_err), 32'(expect_err), "error shown");
		if (!expect_err) begin
			check_eq(value, expected, "result");
		end
	endtask

	task automatic press_key(input logic [3:0] code, input bit settle);
		int rises;
		rises = beep_rises;
		@(posedge sys_clk);
		key     <= code;
		pressed <= 1'b1;
		repeat (HOLD_CYCLES) @(posedge sys_clk);
		pressed <= 1'b0;
		repeat (HOLD_CYCLES) @(posedge sys_clk);
		check_eq(32'(beep_rises - rises), 32'd1, "beep pulses for one key");
		model_st = calc_ref(model_st, code);
		if (settle) begin
			repeat (SETTLE_CYCLES) @(posedge sys_clk);   // scan, divide and conversion
			check_display();
		end
	endtask

	task automatic type_keys(input string keys, input bit settle);
		for (int i = 0; i < keys.len(); i++) begin
			press_key(char_to_key(keys[i]), settle);
		end
	endtask

	initial begin
		logic [3:0] code;
		int         r;
		reset    = 1'b1;
		pressed  = 1'b0;
		key      = 4'd0;
		model_st = '0;
		void'($urandom(94429));
		repeat (16) @(posedge sys_clk);
		reset <= 1'b0;
		@(negedge sys_clk);

		check_eq(32'(beep), 32'd0, "beep after reset");
		check_eq(32'(col), 32'he, "col after reset");   // column 0 driven low
		check_eq(32'(sel), 32'd0, "sel after reset");
		check_display();

		type_keys("16*40=", 1);
		check_value(32'd640, 1'b0);
		type_keys("/8=", 1);
		check_value(32'd80, 1'b0);
		type_keys("C1+1=", 1);
		check_value(32'd2, 1'b0);

		type_keys("C50-20=", 1);
		check_value(32'd30, 1'b0);
		type_keys("-40=+", 1);                // operator after an error still beeps
		check_value(32'd0, 1'b1);
		type_keys("C999*999=", 1);
		check_value(32'd998001, 1'b0);
		type_keys("C1000*1000=", 1);
		check_value(32'd0, 1'b1);
		type_keys("C7/0=", 1);
		check_value(32'd0, 1'b1);
		type_keys("C100-1=+1=*3=", 1);
		check_value(32'd300, 1'b0);
		type_keys("C1234567=", 1);            // seventh digit dropped
		check_value(32'd123456, 1'b0);

		for (int i = 0; i < 40; i++) begin
			r = $urandom % 18;
			if (r < 14) begin
				code = 4'(r);
			end else if (r < 17) begin
				code = KEY_EQ;
			end else begin
				code = KEY_CLR;
			end
			press_key(code, 1);
		end

		// keys back to back, display only read at the end
		type_keys("C654321/9=*2=+5=", 0);
		repeat (SETTLE_CYCLES) @(posedge sys_clk);
		check_display();
		check_value(32'd145409, 1'b0);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== verilog.f ====
design/calc_pkg.sv
design/credit_fifo.sv
design/keypad_scan.sv
design/calc_core.sv
design/seg_display.sv
design/calc_top.sv
verif/keypad_model.sv
verif/calc_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the calculator testbench with Verilator and run it
cd "$(dirname "$0")" \
	&& verilator --binary --timing -Wno-fatal --top-module calc_tb -f verilog.f -o calc_sim \
	&& ./obj_dir/calc_sim \
	|| { echo "simulation failed"; exit 1; }
